//--- hdl/dual_issue_pkg.sv
package dual_issue_pkg;

  // --------------------
  // widths
  localparam int data_width     = 32;  // operand and result width
  localparam int num_regs       = 16;  // architectural registers
  localparam int reg_addr_width = 4;   // log2 of num_regs
  localparam int imm_width      = 16;  // zero extended on use

  // --------------------
  // opcodes
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_sll = 3'd5,  // shift by b[4:0]
    op_srl = 3'd6,  // logical, shift by b[4:0]
    op_li  = 3'd7   // imm only, operands ignored
  } alu_op_e;

  // --------------------
  // issue side
  typedef struct packed {
    logic                      valid;  // lane carries an instruction
    alu_op_e                   op;
    logic [reg_addr_width-1:0] rd;     // destination
    logic [reg_addr_width-1:0] rs1;    // source a
    logic [reg_addr_width-1:0] rs2;    // source b
    logic [imm_width-1:0]      imm;
  } issue_slot_t;

  typedef struct packed {
    issue_slot_t lane1;  // later in program order
    issue_slot_t lane0;
  } issue_pair_t;

  // execute side, operands already resolved
  typedef struct packed {
    logic                      valid;
    alu_op_e                   op;
    logic [reg_addr_width-1:0] rd;
    logic [data_width-1:0]     a;
    logic [data_width-1:0]     b;
    logic [imm_width-1:0]      imm;
  } exec_slot_t;

  typedef struct packed {
    exec_slot_t lane1;
    exec_slot_t lane0;
  } exec_pair_t;

  // retire side, doubles as writeback request
  typedef struct packed {
    logic                      valid;
    logic [reg_addr_width-1:0] rd;
    logic [data_width-1:0]     result;
  } retire_slot_t;

  typedef struct packed {
    retire_slot_t lane1;
    retire_slot_t lane0;
  } retire_pair_t;

endpackage

//--- hdl/register_file.sv
`timescale 1ns/10ps

module register_file (
  input  logic                                      clk,
  input  logic                                      reset,

  // write ports, port 2 is lane 1
  input  logic                                      write1,
  input  logic [dual_issue_pkg::reg_addr_width-1:0] write_address1,
  input  logic [dual_issue_pkg::data_width-1:0]     write_data1,
  input  logic                                      write2,
  input  logic [dual_issue_pkg::reg_addr_width-1:0] write_address2,
  input  logic [dual_issue_pkg::data_width-1:0]     write_data2,

  // read ports, suffix _x_y is operand x of lane y
  input  logic [dual_issue_pkg::reg_addr_width-1:0] read_address_1_1,
  input  logic [dual_issue_pkg::reg_addr_width-1:0] read_address_2_1,
  input  logic [dual_issue_pkg::reg_addr_width-1:0] read_address_1_2,
  input  logic [dual_issue_pkg::reg_addr_width-1:0] read_address_2_2,
  output logic [dual_issue_pkg::data_width-1:0]     read_data_1_1,
  output logic [dual_issue_pkg::data_width-1:0]     read_data_2_1,
  output logic [dual_issue_pkg::data_width-1:0]     read_data_1_2,
  output logic [dual_issue_pkg::data_width-1:0]     read_data_2_2
);

  import dual_issue_pkg::*;

  logic [data_width-1:0] regfile [num_regs];  // no hardwired zero

  // --------------------
  // write side
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regfile[i] <= '0;  // all registers ordinary
      end
    end else begin
      if (write1) begin
        regfile[write_address1] <= write_data1;  // lane 0 first
      end
      if (write2) begin
        regfile[write_address2] <= write_data2;  // lane 1 overrides on collision
      end
    end
  end

  // --------------------
  // read side
  // plain array lookups, a write shows up the cycle after its edge
  always_comb begin
    read_data_1_1 = regfile[read_address_1_1];
    read_data_2_1 = regfile[read_address_2_1];
    read_data_1_2 = regfile[read_address_1_2];
    read_data_2_2 = regfile[read_address_2_2];
  end

  // an unknown index would corrupt an unknown register
  a_write1_addr_known : assert property (
    @(posedge clk) disable iff (reset)
    write1 |-> !$isunknown(write_address1)
  ) else $error("write_address1 unknown while write1 set");

  a_write2_addr_known : assert property (
    @(posedge clk) disable iff (reset)
    write2 |-> !$isunknown(write_address2)
  ) else $error("write_address2 unknown while write2 set");

endmodule

//--- hdl/operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass (
  input  dual_issue_pkg::issue_pair_t               issue,
  input  logic [dual_issue_pkg::data_width-1:0]     rf_data_1_1,  // lane 0 rs1
  input  logic [dual_issue_pkg::data_width-1:0]     rf_data_2_1,  // lane 0 rs2
  input  logic [dual_issue_pkg::data_width-1:0]     rf_data_1_2,  // lane 1 rs1
  input  logic [dual_issue_pkg::data_width-1:0]     rf_data_2_2,  // lane 1 rs2
  input  dual_issue_pkg::retire_pair_t              exec_fwd,     // alu outputs
  input  dual_issue_pkg::retire_pair_t              wb_fwd,       // retire pair
  output dual_issue_pkg::exec_pair_t                operands
);

  import dual_issue_pkg::*;

  // --------------------
  // youngest producer wins
  function automatic logic [data_width-1:0] pick_operand(
    input logic [reg_addr_width-1:0] src,
    input logic [data_width-1:0]     rf_val,
    input retire_pair_t              ex,
    input retire_pair_t              wb
  );
    logic [data_width-1:0] val;
    if (ex.lane1.valid && ex.lane1.rd == src) begin
      val = ex.lane1.result;  // one cycle back, later lane
    end else if (ex.lane0.valid && ex.lane0.rd == src) begin
      val = ex.lane0.result;
    end else if (wb.lane1.valid && wb.lane1.rd == src) begin
      val = wb.lane1.result;  // rf not written until end of cycle
    end else if (wb.lane0.valid && wb.lane0.rd == src) begin
      val = wb.lane0.result;
    end else begin
      val = rf_val;  // settled state
    end
    return val;
  endfunction

  // --------------------
  always_comb begin
    operands.lane0.valid = issue.lane0.valid;
    operands.lane0.op    = issue.lane0.op;
    operands.lane0.rd    = issue.lane0.rd;
    operands.lane0.imm   = issue.lane0.imm;
    operands.lane0.a     = pick_operand(issue.lane0.rs1, rf_data_1_1, exec_fwd, wb_fwd);
    operands.lane0.b     = pick_operand(issue.lane0.rs2, rf_data_2_1, exec_fwd, wb_fwd);

    operands.lane1.valid = issue.lane1.valid;
    operands.lane1.op    = issue.lane1.op;
    operands.lane1.rd    = issue.lane1.rd;
    operands.lane1.imm   = issue.lane1.imm;
    operands.lane1.a     = pick_operand(issue.lane1.rs1, rf_data_1_2, exec_fwd, wb_fwd);
    operands.lane1.b     = pick_operand(issue.lane1.rs2, rf_data_2_2, exec_fwd, wb_fwd);

    // no path from lane 0 alu into lane 1 of the same pair
    a_no_intra_pair_dep : assert final (
      !(issue.lane0.valid && issue.lane1.valid &&
        (issue.lane1.rs1 == issue.lane0.rd || issue.lane1.rs2 == issue.lane0.rd))
    ) else $error("lane 1 reads lane 0 rd %0d within one pair", issue.lane0.rd);
  end

endmodule

//--- hdl/alu_lane.sv
`timescale 1ns/10ps

module alu_lane (
  input  dual_issue_pkg::exec_slot_t   operands,
  output dual_issue_pkg::retire_slot_t result
);

  import dual_issue_pkg::*;

  logic [4:0]            shamt;  // low bits of b only
  logic [data_width-1:0] imm_ext;

  assign shamt   = operands.b[4:0];
  assign imm_ext = {{(data_width - imm_width){1'b0}}, operands.imm};  // zero extend

  // --------------------
  // datapath
  always_comb begin
    result.valid = operands.valid;  // pass through
    result.rd    = operands.rd;

    case (operands.op)
      op_add: begin
        result.result = operands.a + operands.b;
      end
      op_sub: begin
        result.result = operands.a - operands.b;  // wraps
      end
      op_and: begin
        result.result = operands.a & operands.b;
      end
      op_or: begin
        result.result = operands.a | operands.b;
      end
      op_xor: begin
        result.result = operands.a ^ operands.b;
      end
      op_sll: begin
        result.result = operands.a << shamt;
      end
      op_srl: begin
        result.result = operands.a >> shamt;  // zero fill
      end
      op_li: begin
        result.result = imm_ext;  // a and b ignored
      end
      default: begin
        result.result = '0;  // unreachable with 3 bit op
      end
    endcase
  end

endmodule

//--- hdl/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
  parameter type payload_t = logic  // exec_pair_t or retire_pair_t
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t d,
  output payload_t q
);

  // --------------------
  // one cycle of pipeline delay
  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;  // drops every valid bit
    end else begin
      q <= d;   // advances every cycle
    end
  end

  // no unknown bits leave the stage once out of reset
  a_q_known : assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(q)
  ) else $error("stage register holds unknown bits");

endmodule

//--- hdl/dual_issue_core.sv
`timescale 1ns/10ps

module dual_issue_core (
  input  logic                         clk,
  input  logic                         reset,
  input  dual_issue_pkg::issue_pair_t  issue,   // new pair every cycle
  output dual_issue_pkg::retire_pair_t retire   // 2 cycles after issue
);

  import dual_issue_pkg::*;

  // issue stage
  logic [data_width-1:0] rf_data_1_1;  // lane 0 rs1
  logic [data_width-1:0] rf_data_2_1;  // lane 0 rs2
  logic [data_width-1:0] rf_data_1_2;  // lane 1 rs1
  logic [data_width-1:0] rf_data_2_2;  // lane 1 rs2
  exec_pair_t            issue_operands;

  // execute stage
  exec_pair_t            exec_operands;
  retire_pair_t          exec_result;   // also the execute forward

  // --------------------
  // register file, written from the retire pair
  register_file i_register_file (
    .clk              (clk),
    .reset            (reset),
    .write1           (retire.lane0.valid),
    .write_address1   (retire.lane0.rd),
    .write_data1      (retire.lane0.result),
    .write2           (retire.lane1.valid),  // lane 1 wins collision
    .write_address2   (retire.lane1.rd),
    .write_data2      (retire.lane1.result),
    .read_address_1_1 (issue.lane0.rs1),
    .read_address_2_1 (issue.lane0.rs2),
    .read_address_1_2 (issue.lane1.rs1),
    .read_address_2_2 (issue.lane1.rs2),
    .read_data_1_1    (rf_data_1_1),
    .read_data_2_1    (rf_data_2_1),
    .read_data_1_2    (rf_data_1_2),
    .read_data_2_2    (rf_data_2_2)
  );

  // --------------------
  // operand select
  operand_bypass i_operand_bypass (
    .issue       (issue),
    .rf_data_1_1 (rf_data_1_1),
    .rf_data_2_1 (rf_data_2_1),
    .rf_data_1_2 (rf_data_1_2),
    .rf_data_2_2 (rf_data_2_2),
    .exec_fwd    (exec_result),  // one cycle older
    .wb_fwd      (retire),       // two cycles older
    .operands    (issue_operands)
  );

  stage_reg #(
    .payload_t (exec_pair_t)
  ) i_exec_reg (
    .clk   (clk),
    .reset (reset),
    .d     (issue_operands),
    .q     (exec_operands)
  );

  // --------------------
  // execute, one alu per lane
  alu_lane i_alu_lane0 (
    .operands (exec_operands.lane0),
    .result   (exec_result.lane0)
  );

  alu_lane i_alu_lane1 (
    .operands (exec_operands.lane1),
    .result   (exec_result.lane1)
  );

  // --------------------
  // writeback
  stage_reg #(
    .payload_t (retire_pair_t)
  ) i_retire_reg (
    .clk   (clk),
    .reset (reset),
    .d     (exec_result),
    .q     (retire)  // output and write request
  );

endmodule

//--- include/dual_issue_tb_model.svh
`ifndef DUAL_ISSUE_TB_MODEL_SVH
`define DUAL_ISSUE_TB_MODEL_SVH

// --------------------
// sequential reference, one pair per step
logic [data_width-1:0] ref_regs [num_regs];  // architectural state

function automatic void clear_ref_regs();
  for (int i = 0; i < num_regs; i++) begin
    ref_regs[i] = '0;  // matches reset
  end
endfunction

function automatic logic [data_width-1:0] alu_result(
  input alu_op_e               op,
  input logic [data_width-1:0] a,
  input logic [data_width-1:0] b,
  input logic [imm_width-1:0]  imm
);
  logic [4:0]            amount;
  logic [data_width-1:0] value;
  amount = b[4:0];  // upper bits of b ignored
  case (op)
    op_add:  value = a + b;
    op_sub:  value = a - b;  // modulo 2**32
    op_and:  value = a & b;
    op_or:   value = a | b;
    op_xor:  value = a ^ b;
    op_sll:  value = a << amount;
    op_srl:  value = a >> amount;  // zeros shifted in
    default: value = {{(data_width - imm_width){1'b0}}, imm};  // op_li
  endcase
  return value;
endfunction

// both lanes see the state before the pair, lane 1 lands last
function automatic retire_pair_t step_pair(input issue_pair_t pair);
  retire_pair_t expected;
  expected = '0;
  expected.lane0.valid  = pair.lane0.valid;
  expected.lane0.rd     = pair.lane0.rd;
  expected.lane0.result = alu_result(pair.lane0.op, ref_regs[pair.lane0.rs1],
                                     ref_regs[pair.lane0.rs2], pair.lane0.imm);
  expected.lane1.valid  = pair.lane1.valid;
  expected.lane1.rd     = pair.lane1.rd;
  expected.lane1.result = alu_result(pair.lane1.op, ref_regs[pair.lane1.rs1],
                                     ref_regs[pair.lane1.rs2], pair.lane1.imm);
  if (pair.lane0.valid) begin
    ref_regs[pair.lane0.rd] = expected.lane0.result;
  end
  if (pair.lane1.valid) begin
    ref_regs[pair.lane1.rd] = expected.lane1.result;  // wins on same rd
  end
  return expected;
endfunction

`endif

//--- bench/dual_issue_core_tb.sv
`timescale 1ns/10ps

module dual_issue_core_tb;

  import dual_issue_pkg::*;

  `include "dual_issue_tb_model.svh"

  localparam int num_entries = 41;               // rows in stimulus table
  localparam int cycle_limit = num_entries + 20;  // reset, drain and margin

  logic                clk;
  logic                reset;
  issue_pair_t         issue;
  retire_pair_t        retire;

  issue_pair_t         stim [num_entries];  // stimulus table
  retire_pair_t        expected_q [$];      // scoreboard, oldest first
  int                  fill        = 0;     // table rows written
  int                  error_count = 0;
  int                  check_count = 0;
  int                  cycle_count = 0;

  dual_issue_core i_dut (
    .clk    (clk),
    .reset  (reset),
    .issue  (issue),
    .retire (retire)
  );

  always #50 clk = ~clk;  // 100 ns period

  // --------------------
  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run still busy after %0d clock cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("Error: time %0t, %s is %h, expected %h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  // rd and result only matter for a valid lane
  task automatic check_retire(input retire_pair_t expected);
    compare_value("retire.lane0.valid", retire.lane0.valid, expected.lane0.valid);
    if (expected.lane0.valid) begin
      compare_value("retire.lane0.rd", retire.lane0.rd, expected.lane0.rd);
      compare_value("retire.lane0.result", retire.lane0.result, expected.lane0.result);
    end
    compare_value("retire.lane1.valid", retire.lane1.valid, expected.lane1.valid);
    if (expected.lane1.valid) begin
      compare_value("retire.lane1.rd", retire.lane1.rd, expected.lane1.rd);
      compare_value("retire.lane1.result", retire.lane1.result, expected.lane1.result);
    end
  endtask

  // --------------------
  // table helpers
  function automatic issue_slot_t make_slot(input alu_op_e op,
                                            input logic [reg_addr_width-1:0] rd,
                                            input logic [reg_addr_width-1:0] rs1,
                                            input logic [reg_addr_width-1:0] rs2);
    issue_slot_t slot;
    slot       = '0;
    slot.valid = 1'b1;
    slot.op    = op;
    slot.rd    = rd;
    slot.rs1   = rs1;
    slot.rs2   = rs2;
    return slot;
  endfunction

  function automatic issue_slot_t make_li(input logic [reg_addr_width-1:0] rd,
                                          input logic [imm_width-1:0] imm);
    issue_slot_t slot;
    slot     = make_slot(op_li, rd, ~rd, ~rd);  // sources unused, kept off rd
    slot.imm = imm;
    return slot;
  endfunction

  task automatic add_pair(input issue_slot_t lane0, input issue_slot_t lane1);
    if (fill < num_entries) begin
      stim[fill].lane0 = lane0;
      stim[fill].lane1 = lane1;
    end
    fill++;
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    // every register reads back zero after reset
    add_pair(make_li(15, 16'h0000), make_li(14, 16'h0000));
    for (int k = 0; k < 8; k++) begin
      add_pair(make_slot(op_add, k, k, 15), make_slot(op_add, k + 8, k + 8, 14));
    end
    // all opcodes, chained through both forward paths
    add_pair(make_li(1, 16'ha5c3), make_li(2, 16'h0f0f));
    add_pair(make_li(3, 16'h0025), make_li(4, 16'hffff));     // shift amount 5 after mask
    add_pair(make_slot(op_sll, 5, 1, 3), make_slot(op_sub, 6, 2, 4));
    add_pair(make_slot(op_add, 7, 5, 6), make_slot(op_xor, 8, 1, 4));
    add_pair(make_slot(op_and, 9, 7, 8), make_slot(op_or, 10, 5, 2));
    add_pair(make_slot(op_srl, 11, 7, 3), make_slot(op_sll, 12, 4, 7));
    add_pair(make_slot(op_srl, 13, 6, 2), make_slot(op_sub, 14, 12, 11));
    add_pair(make_slot(op_or, 15, 13, 14), make_slot(op_and, 0, 6, 1));
    add_pair(make_slot(op_sub, 1, 15, 0), make_slot(op_add, 2, 9, 10));
    add_pair(make_slot(op_xor, 3, 1, 11), make_slot(op_srl, 4, 5, 6));
    // same rd on both lanes
    add_pair(make_li(7, 16'h1111), make_li(7, 16'h2222));
    add_pair('0, '0);
    add_pair(make_slot(op_or, 8, 7, 7), make_slot(op_add, 9, 7, 7));   // via writeback
    add_pair(make_li(10, 16'h3333), make_li(10, 16'h4444));
    add_pair(make_slot(op_or, 11, 10, 10), make_slot(op_sub, 12, 10, 3));  // via execute
    // idle gap, state must hold
    add_pair('0, '0);
    add_pair('0, '0);
    add_pair('0, '0);
    add_pair(make_slot(op_or, 13, 11, 10), make_slot(op_add, 14, 8, 7));  // r7, r10 from rf
    add_pair('0, make_li(5, 16'hbeef));                         // lane 1 alone
    add_pair(make_slot(op_add, 6, 5, 5), '0);                   // lane 0 alone
    // random load immediates
    for (int k = 0; k < 8; k++) begin
      rnd = $urandom;
      add_pair(make_li(rnd[3:0], rnd[19:4]), make_li(rnd[23:20], rnd[31:16]));
      stim[fill - 1].lane1.rs1 = ~rnd[3:0];  // keep clear of lane 0 rd
      stim[fill - 1].lane1.rs2 = ~rnd[3:0];
    end
    add_pair(make_slot(op_add, 0, 1, 2), make_slot(op_or, 4, 5, 6));
    add_pair(make_slot(op_add, 7, 8, 9), make_slot(op_sub, 10, 11, 12));
    add_pair(make_slot(op_or, 13, 14, 15), make_slot(op_xor, 1, 2, 3));
  endtask

  // --------------------
  // main sequence
  initial begin
    void'($urandom(11));
    clk   = 1'b0;
    reset = 1'b1;
    issue = '0;
    clear_ref_regs();
    build_table();
    if (fill != num_entries) begin
      $display("stimulus table holds %0d rows but %0d were expected", fill, num_entries);
      error_count++;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare_value("retire.lane0.valid", retire.lane0.valid, 1'b0);
    compare_value("retire.lane1.valid", retire.lane1.valid, 1'b0);
    for (int i = 0; i < num_entries + 2; i++) begin
      @(posedge clk);
      if (i < num_entries) begin
        issue <= stim[i];
        expected_q.push_back(step_pair(stim[i]));
      end else begin
        issue <= '0;  // drain
      end
      @(negedge clk);
      if (i >= 2) begin
        check_retire(expected_q.pop_front());  // issued two cycles back
      end else begin
        compare_value("retire.lane0.valid", retire.lane0.valid, 1'b0);
        compare_value("retire.lane1.valid", retire.lane1.valid, 1'b0);
      end
    end
    if (expected_q.size() != 0) begin
      $display("%0d expected retire pairs were never compared", expected_q.size());
      error_count++;
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- dual_issue.f
+incdir+include
hdl/dual_issue_pkg.sv
hdl/register_file.sv
hdl/operand_bypass.sv
hdl/alu_lane.sv
hdl/stage_reg.sv
hdl/dual_issue_core.sv
bench/dual_issue_core_tb.sv
